//--- hw/simd_alu_pkg.sv
// shared types for the packed-SIMD ALU core, imported by every RTL file and the testbench
package simd_alu_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // full data word
  localparam int unsigned WORD_W  = 32;
  // one byte slice of the adder and comparator
  localparam int unsigned LANE_W  = 8;
  // byte lanes per word
  localparam int unsigned N_LANES = WORD_W / LANE_W;

  ////////////////////////////////////////////////////////////
  // opcodes and vector modes
  ////////////////////////////////////////////////////////////

  // arithmetic and logic ops live in the low half of the code space
  typedef enum logic [4:0] {
    ALU_ADD  = 5'h00,
    ALU_SUB  = 5'h01,
    ALU_AND  = 5'h02,
    ALU_OR   = 5'h03,
    ALU_XOR  = 5'h04,
    // element-wise compares, one mask per element
    ALU_EQ   = 5'h08,
    ALU_NE   = 5'h09,
    ALU_LTS  = 5'h0a,
    ALU_LTU  = 5'h0b,
    ALU_GES  = 5'h0c,
    ALU_GEU  = 5'h0d,
    // scalar set-less-than, result in bit 0
    ALU_SLTS = 5'h0e,
    ALU_SLTU = 5'h0f,
    // element-wise select of a or b
    ALU_MIN  = 5'h10,
    ALU_MAX  = 5'h11,
    ALU_MINU = 5'h12,
    ALU_MAXU = 5'h13
  } alu_op_e;

  // same encoding as the processor decoder, 2'b01 is unused
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  ////////////////////////////////////////////////////////////
  // data views and lane structs
  ////////////////////////////////////////////////////////////

  // one word, split into bytes or into halfwords
  typedef union packed {
    logic [WORD_W-1:0]                word;
    logic [N_LANES-1:0][LANE_W-1:0]   bytes;
    logic [1:0][2*LANE_W-1:0]         halves;
  } simd_word_u;

  // per-lane adder and comparator control
  typedef struct packed {
    logic carry_join;   // take carry from the lane below
    logic carry_in;     // injected carry when the chain is cut
    logic negate_b;     // invert operand b for subtraction
    logic cmp_signed;   // top byte of a signed element
  } lane_ctrl_t;

  // per-lane results handed to the merge stage
  typedef struct packed {
    logic [LANE_W-1:0] sum;
    logic [LANE_W-1:0] logic_res;
    logic              eq;
    logic              gt;
  } lane_out_t;

endpackage

//--- hw/simd_lane_ctrl.sv
// decodes opcode and vector mode into carry, negate and signedness controls for each byte lane
`timescale 1ns/1ps

module simd_lane_ctrl
  import simd_alu_pkg::*;
(
  input  alu_op_e                   operator_i,
  input  vec_mode_e                 vector_mode_i,
  output lane_ctrl_t [N_LANES-1:0]  lane_ctrl_o
);

  ////////////////////////////////////////////////////////////
  // element boundaries
  ////////////////////////////////////////////////////////////

  logic [N_LANES-1:0] elem_low;   // lowest byte of an element
  logic [N_LANES-1:0] elem_top;   // highest byte of an element
  logic               is_sub;
  logic               signed_op;

  // a lane is an element's low byte when its index is a multiple of the element size
  always_comb begin
    int unsigned elem_bytes;

    case (vector_mode_i)
      VEC_MODE32: elem_bytes = 4;
      VEC_MODE16: elem_bytes = 2;
      default:    elem_bytes = 1;
    endcase

    for (int unsigned i = 0; i < N_LANES; i++) begin
      elem_low[i] = (i % elem_bytes) == 0;
      elem_top[i] = (i % elem_bytes) == (elem_bytes - 1);
    end
  end

  ////////////////////////////////////////////////////////////
  // opcode classes
  ////////////////////////////////////////////////////////////

  assign is_sub = (operator_i == ALU_SUB);

  // the signed flavours of compare and min/max
  assign signed_op = (operator_i == ALU_LTS)  || (operator_i == ALU_GES) ||
                     (operator_i == ALU_SLTS) || (operator_i == ALU_MIN) ||
                     (operator_i == ALU_MAX);

  // subtraction is a + ~b + 1, the +1 goes into each element's low byte
  // inside an element the carry always ripples, at a boundary it is cut
  always_comb begin
    for (int unsigned i = 0; i < N_LANES; i++) begin
      lane_ctrl_o[i].carry_join = ~elem_low[i];
      lane_ctrl_o[i].carry_in   = is_sub & elem_low[i];
      lane_ctrl_o[i].negate_b   = is_sub;
      lane_ctrl_o[i].cmp_signed = signed_op & elem_top[i];
    end
  end

endmodule

//--- hw/simd_byte_lane.sv
// one 8-bit slice of the partitioned adder, comparator and bitwise logic, chained by carry
`timescale 1ns/1ps

module simd_byte_lane
  import simd_alu_pkg::*;
(
  input  logic [LANE_W-1:0] operand_a_i,
  input  logic [LANE_W-1:0] operand_b_i,
  input  lane_ctrl_t        ctrl_i,
  input  logic              carry_i,
  output logic              carry_o,
  input  alu_op_e           operator_i,
  output lane_out_t         lane_o
);

  logic [LANE_W-1:0] adder_b;
  logic              adder_cin;
  logic [LANE_W:0]   sum_ext;
  logic              sign_a;
  logic              sign_b;

  // adder, b optionally inverted for subtraction
  assign adder_b   = ctrl_i.negate_b ? ~operand_b_i : operand_b_i;
  assign adder_cin = ctrl_i.carry_join ? carry_i : ctrl_i.carry_in;
  assign sum_ext   = {1'b0, operand_a_i} + {1'b0, adder_b} + {{LANE_W{1'b0}}, adder_cin};
  assign carry_o   = sum_ext[LANE_W];

  // extra top bit turns the byte into a 9-bit signed value
  // zero extension gives the unsigned compare
  assign sign_a = operand_a_i[LANE_W-1] & ctrl_i.cmp_signed;
  assign sign_b = operand_b_i[LANE_W-1] & ctrl_i.cmp_signed;

  always_comb begin
    lane_o.sum = sum_ext[LANE_W-1:0];
    lane_o.eq  = (operand_a_i == operand_b_i);
    lane_o.gt  = $signed({sign_a, operand_a_i}) > $signed({sign_b, operand_b_i});

    // bitwise ops ignore the vector mode
    case (operator_i)
      ALU_AND: lane_o.logic_res = operand_a_i & operand_b_i;
      ALU_OR:  lane_o.logic_res = operand_a_i | operand_b_i;
      ALU_XOR: lane_o.logic_res = operand_a_i ^ operand_b_i;
      default: lane_o.logic_res = '0;
    endcase
  end

endmodule

//--- hw/simd_lane_merge.sv
// joins byte-lane flags into element compares, selects the ALU result and registers it
`timescale 1ns/1ps

module simd_lane_merge
  import simd_alu_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset_i,
  input  logic                     enable_i,
  input  alu_op_e                  operator_i,
  input  vec_mode_e                vector_mode_i,
  input  logic [WORD_W-1:0]        operand_a_i,
  input  logic [WORD_W-1:0]        operand_b_i,
  input  lane_out_t [N_LANES-1:0]  lane_i,
  output logic [WORD_W-1:0]        result_o,
  output logic                     comparison_result_o,
  output logic                     valid_o
);

  ////////////////////////////////////////////////////////////
  // element compare flags
  ////////////////////////////////////////////////////////////

  logic [N_LANES-1:0] eq_v;
  logic [N_LANES-1:0] gt_v;
  logic [N_LANES-1:0] is_equal;
  logic [N_LANES-1:0] is_greater;
  logic [N_LANES-1:0] cmp_result;
  logic [N_LANES-1:0] sel_a;
  logic               do_min;
  simd_word_u         op_a;
  simd_word_u         op_b;
  simd_word_u         result_d;

  assign op_a = operand_a_i;
  assign op_b = operand_b_i;

  always_comb begin
    for (int i = 0; i < N_LANES; i++) begin
      eq_v[i] = lane_i[i].eq;
      gt_v[i] = lane_i[i].gt;
    end
  end

  // the top byte decides greater, lower bytes only when the upper ones are equal
  // every byte of an element carries the element's flag
  always_comb begin
    case (vector_mode_i)
      VEC_MODE8: begin
        is_equal   = eq_v;
        is_greater = gt_v;
      end
      VEC_MODE16: begin
        is_equal[1:0]   = {2{eq_v[1] & eq_v[0]}};
        is_equal[3:2]   = {2{eq_v[3] & eq_v[2]}};
        is_greater[1:0] = {2{gt_v[1] | (eq_v[1] & gt_v[0])}};
        is_greater[3:2] = {2{gt_v[3] | (eq_v[3] & gt_v[2])}};
      end
      default: begin
        is_equal   = {N_LANES{&eq_v}};
        is_greater = {N_LANES{gt_v[3] | (eq_v[3] & (gt_v[2] |
                              (eq_v[2] & (gt_v[1] | (eq_v[1] & gt_v[0])))))}};
      end
    endcase
  end

  // per-element compare outcome, all zero for the non-compare ops
  always_comb begin
    case (operator_i)
      ALU_EQ:                               cmp_result = is_equal;
      ALU_NE:                               cmp_result = ~is_equal;
      ALU_GES, ALU_GEU:                     cmp_result = is_greater | is_equal;
      ALU_LTS, ALU_LTU, ALU_SLTS, ALU_SLTU: cmp_result = ~(is_greater | is_equal);
      default:                              cmp_result = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // min/max and result mux
  ////////////////////////////////////////////////////////////

  // max picks a only when a is greater
  // min picks a unless a is greater
  assign do_min = (operator_i == ALU_MIN) || (operator_i == ALU_MINU);
  assign sel_a  = is_greater ^ {N_LANES{do_min}};

  always_comb begin
    result_d.word = '0;
    for (int i = 0; i < N_LANES; i++) begin
      case (operator_i)
        ALU_ADD, ALU_SUB:                     result_d.bytes[i] = lane_i[i].sum;
        ALU_AND, ALU_OR, ALU_XOR:             result_d.bytes[i] = lane_i[i].logic_res;
        ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU,
        ALU_GES, ALU_GEU:                     result_d.bytes[i] = {LANE_W{cmp_result[i]}};
        ALU_MIN, ALU_MAX, ALU_MINU, ALU_MAXU: result_d.bytes[i] = sel_a[i] ? op_a.bytes[i]
                                                                           : op_b.bytes[i];
        default:                              result_d.bytes[i] = '0;
      endcase
    end
    // scalar set-less-than only looks at the top element
    if ((operator_i == ALU_SLTS) || (operator_i == ALU_SLTU)) begin
      result_d.word = {{(WORD_W-1){1'b0}}, cmp_result[N_LANES-1]};
    end
  end

  ////////////////////////////////////////////////////////////
  // output register, one cycle after enable
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o             <= 1'b0;
      result_o            <= '0;
      comparison_result_o <= 1'b0;
    end else begin
      valid_o <= enable_i;
      if (enable_i) begin
        result_o            <= result_d.word;
        comparison_result_o <= cmp_result[N_LANES-1];
      end
    end
  end

endmodule

//--- hw/simd_alu.sv
// top of the packed-SIMD ALU core: lane decoder, four byte lanes and the registered merge
`timescale 1ns/1ps

module simd_alu
  import simd_alu_pkg::*;
(
  input  logic               clk,
  input  logic               reset_i,
  input  logic               enable_i,
  input  alu_op_e            operator_i,
  input  vec_mode_e          vector_mode_i,
  input  logic [WORD_W-1:0]  operand_a_i,
  input  logic [WORD_W-1:0]  operand_b_i,
  output logic [WORD_W-1:0]  result_o,
  output logic               comparison_result_o,
  output logic               valid_o
);

  lane_ctrl_t [N_LANES-1:0] lane_ctrl;
  lane_out_t  [N_LANES-1:0] lane_out;
  // carry[i] enters lane i, the top bit is the word carry out and is not used
  logic       [N_LANES:0]   carry;
  simd_word_u               op_a;
  simd_word_u               op_b;

  assign op_a     = operand_a_i;
  assign op_b     = operand_b_i;
  assign carry[0] = 1'b0;

  ////////////////////////////////////////////////////////////
  // lane control
  ////////////////////////////////////////////////////////////

  simd_lane_ctrl u_lane_ctrl (
    .operator_i    (operator_i),
    .vector_mode_i (vector_mode_i),
    .lane_ctrl_o   (lane_ctrl)
  );

  ////////////////////////////////////////////////////////////
  // byte lanes, carry ripples upward
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < N_LANES; i++) begin : gen_lane
    simd_byte_lane u_lane (
      .operand_a_i (op_a.bytes[i]),
      .operand_b_i (op_b.bytes[i]),
      .ctrl_i      (lane_ctrl[i]),
      .carry_i     (carry[i]),
      .carry_o     (carry[i+1]),
      .operator_i  (operator_i),
      .lane_o      (lane_out[i])
    );
  end

  // element merge and output register
  simd_lane_merge u_merge (
    .clk                 (clk),
    .reset_i             (reset_i),
    .enable_i            (enable_i),
    .operator_i          (operator_i),
    .vector_mode_i       (vector_mode_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .lane_i              (lane_out),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o),
    .valid_o             (valid_o)
  );

endmodule

//--- test/simd_alu_properties.sv
// concurrent checks on the SIMD ALU output register and valid pulse, bound into the top level
`timescale 1ns/1ps

module simd_alu_properties
  import simd_alu_pkg::*;
(
  input logic              clk,
  input logic              reset_i,
  input logic              enable_i,
  input alu_op_e           operator_i,
  input vec_mode_e         vector_mode_i,
  input logic [WORD_W-1:0] operand_a_i,
  input logic [WORD_W-1:0] operand_b_i,
  input logic [WORD_W-1:0] result_o,
  input logic              comparison_result_o,
  input logic              valid_o
);

  int unsigned err_count = 0;
  simd_word_u  a_u;
  simd_word_u  b_u;
  simd_word_u  res_u;
  logic [15:0] sum_lo;
  logic [15:0] sum_hi;
  logic        is_cmp;

  assign a_u    = operand_a_i;
  assign b_u    = operand_b_i;
  assign res_u  = result_o;
  // halfword sums wrap on their own, no carry between them
  assign sum_lo = a_u.halves[0] + b_u.halves[0];
  assign sum_hi = a_u.halves[1] + b_u.halves[1];
  assign is_cmp = operator_i inside {ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU,
                                     ALU_GES, ALU_GEU, ALU_SLTS, ALU_SLTU};

  // reset clears the register
  a_reset_clear: assert property (@(posedge clk)
    reset_i |=> !valid_o && result_o == '0 && !comparison_result_o)
    else begin $error("outputs not cleared one cycle after reset"); err_count++; end

  // one cycle latency
  a_valid_rise: assert property (@(posedge clk) disable iff (reset_i)
    enable_i |=> valid_o)
    else begin $error("valid_o missing one cycle after enable"); err_count++; end

  a_valid_drop: assert property (@(posedge clk) disable iff (reset_i)
    !enable_i |=> !valid_o)
    else begin $error("valid_o high without a preceding enable"); err_count++; end

  a_hold: assert property (@(posedge clk) disable iff (reset_i)
    !enable_i |=> $stable(result_o) && $stable(comparison_result_o))
    else begin $error("result changed while enable was low"); err_count++; end

  a_add16: assert property (@(posedge clk) disable iff (reset_i)
    enable_i && operator_i == ALU_ADD && vector_mode_i == VEC_MODE16
    |=> res_u.halves[0] == $past(sum_lo) && res_u.halves[1] == $past(sum_hi))
    else begin $error("halfword add carried across the element boundary"); err_count++; end

  a_cmp_zero: assert property (@(posedge clk) disable iff (reset_i)
    enable_i && !is_cmp |=> !comparison_result_o)
    else begin $error("compare flag set for a non-compare op"); err_count++; end

endmodule

bind simd_alu simd_alu_properties u_props (
  .clk                 (clk),
  .reset_i             (reset_i),
  .enable_i            (enable_i),
  .operator_i          (operator_i),
  .vector_mode_i       (vector_mode_i),
  .operand_a_i         (operand_a_i),
  .operand_b_i         (operand_b_i),
  .result_o            (result_o),
  .comparison_result_o (comparison_result_o),
  .valid_o             (valid_o)
);

//--- test/tb_simd_alu.sv
// testbench for the SIMD ALU core: LFSR operands, a reference model and a check per result
`timescale 1ns/1ps

module tb_simd_alu
  import simd_alu_pkg::*;
();

  logic        clk;
  logic        reset_i;
  logic        enable_i;
  alu_op_e     operator_i;
  vec_mode_e   vector_mode_i;
  logic [31:0] operand_a_i;
  logic [31:0] operand_b_i;
  logic [31:0] result_o;
  logic        comparison_result_o;
  logic        valid_o;
  logic [31:0] lfsr_state;

  // directed pairs for carries across boundaries, sign flips and equal or partly equal words
  logic [31:0] dir_a [8] = '{32'hffffffff, 32'h00ff00ff, 32'h00000000, 32'h80808080,
                             32'h7f7f7f7f, 32'h12345678, 32'h12345678, 32'h12345678};
  logic [31:0] dir_b [8] = '{32'h01010101, 32'h00010001, 32'h01010101, 32'h7f7f7f7f,
                             32'h80808080, 32'h12345678, 32'h12355678, 32'h12345679};

  simd_alu u_dut (
    .clk                 (clk),
    .reset_i             (reset_i),
    .enable_i            (enable_i),
    .operator_i          (operator_i),
    .vector_mode_i       (vector_mode_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o),
    .valid_o             (valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // stimulus source
  ////////////////////////////////////////////////////////////

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  task automatic random_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic int elem_width(input vec_mode_e mode);
    case (mode)
      VEC_MODE8:  return 8;
      VEC_MODE16: return 16;
      default:    return 32;
    endcase
  endfunction

  // element i zero extended to a word
  function automatic logic [31:0] elem_get(input simd_word_u u, input vec_mode_e mode,
                                           input int i);
    case (mode)
      VEC_MODE8:  return {24'b0, u.bytes[i]};
      VEC_MODE16: return {16'b0, u.halves[i]};
      default:    return u.word;
    endcase
  endfunction

  // flipping the sign bit maps signed order onto unsigned order
  function automatic logic elem_less(input alu_op_e op, input logic [31:0] a,
                                     input logic [31:0] b, input int w);
    logic [31:0] bias;
    bias = (op inside {ALU_LTS, ALU_GES, ALU_SLTS, ALU_MIN, ALU_MAX}) ? (32'h1 << (w - 1)) : '0;
    return (a ^ bias) < (b ^ bias);
  endfunction

  function automatic logic elem_true(input alu_op_e op, input logic [31:0] a,
                                     input logic [31:0] b, input int w);
    case (op)
      ALU_EQ:           return a == b;
      ALU_NE:           return a != b;
      ALU_GES, ALU_GEU: return !elem_less(op, a, b, w);
      default:          return elem_less(op, a, b, w);
    endcase
  endfunction

  function automatic logic [31:0] expect_result(input alu_op_e op, input vec_mode_e mode,
                                                input logic [31:0] a, input logic [31:0] b);
    simd_word_u  ua;
    simd_word_u  ub;
    simd_word_u  res;
    logic [31:0] ea;
    logic [31:0] eb;
    logic [31:0] er;
    logic [31:0] mask;
    int          w;
    ua.word  = a;
    ub.word  = b;
    res.word = '0;
    w        = elem_width(mode);
    mask     = (w == 32) ? 32'hffffffff : ((32'h1 << w) - 1);
    for (int i = 0; i < 32 / w; i++) begin
      ea = elem_get(ua, mode, i);
      eb = elem_get(ub, mode, i);
      case (op)
        ALU_ADD:           er = ea + eb;
        ALU_SUB:           er = ea - eb;
        ALU_AND:           er = ea & eb;
        ALU_OR:            er = ea | eb;
        ALU_XOR:           er = ea ^ eb;
        ALU_MIN, ALU_MINU: er = elem_less(op, ea, eb, w) ? ea : eb;
        ALU_MAX, ALU_MAXU: er = elem_less(op, ea, eb, w) ? eb : ea;
        default:           er = elem_true(op, ea, eb, w) ? mask : '0;
      endcase
      er = er & mask;
      case (mode)
        VEC_MODE8:  res.bytes[i]  = er[7:0];
        VEC_MODE16: res.halves[i] = er[15:0];
        default:    res.word      = er;
      endcase
    end
    // ea and eb still hold the top element here
    if (op inside {ALU_SLTS, ALU_SLTU}) begin
      res.word = {31'b0, elem_true(op, ea, eb, w)};
    end
    return res.word;
  endfunction

  // flag of the top element and zero for non-compare ops
  function automatic logic expect_cmp(input alu_op_e op, input vec_mode_e mode,
                                      input logic [31:0] a, input logic [31:0] b);
    simd_word_u ua;
    simd_word_u ub;
    int         top;
    ua.word = a;
    ub.word = b;
    top     = 32 / elem_width(mode) - 1;
    if (!(op inside {ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU, ALU_SLTS, ALU_SLTU}))
      return 1'b0;
    return elem_true(op, elem_get(ua, mode, top), elem_get(ub, mode, top), elem_width(mode));
  endfunction

  ////////////////////////////////////////////////////////////
  // drive and check
  ////////////////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic wait_valid(input string name);
    int cycles;
    cycles = 0;
    while (!valid_o && cycles < 10) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!valid_o) begin
      $display("%s: valid_o never went high after enable", name);
      stop_on_error();
    end
  endtask

  // enable stays high across calls, so consecutive calls run back to back
  task automatic apply(input alu_op_e op, input vec_mode_e mode,
                       input logic [31:0] a, input logic [31:0] b);
    string       name;
    logic [31:0] exp_res;
    logic        exp_cmp;
    name          = {op.name(), "/", mode.name()};
    exp_res       = expect_result(op, mode, a, b);
    exp_cmp       = expect_cmp(op, mode, a, b);
    enable_i      = 1'b1;
    operator_i    = op;
    vector_mode_i = mode;
    operand_a_i   = a;
    operand_b_i   = b;
    @(posedge clk);
    #1;
    wait_valid(name);
    assert (result_o == exp_res) else begin
      $display("ERR %s result: expected %h, actual %h", name, exp_res, result_o);
      stop_on_error();
    end
    assert (comparison_result_o == exp_cmp) else begin
      $display("ERR %s compare: expected %b, actual %b", name, exp_cmp, comparison_result_o);
      stop_on_error();
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      enable_i = 1'b0;
      @(posedge clk);
      #1;
      assert (!valid_o) else begin
        $display("valid_o was high in a cycle without enable");
        stop_on_error();
      end
    end
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    vec_mode_e   mode;
    alu_op_e     op;
    lfsr_state    = 32'hccc6;
    reset_i       = 1'b1;
    enable_i      = 1'b0;
    operator_i    = ALU_ADD;
    vector_mode_i = VEC_MODE32;
    operand_a_i   = '0;
    operand_b_i   = '0;
    repeat (8) @(posedge clk);
    #1;
    reset_i = 1'b0;
    idle(2);

    // every op in every mode, directed pairs then random ones
    mode = mode.first();
    do begin
      op = op.first();
      do begin
        for (int k = 0; k < 8; k++) begin
          apply(op, mode, dir_a[k], dir_b[k]);
        end
        for (int k = 0; k < 12; k++) begin
          random_word(a);
          random_word(b);
          apply(op, mode, a, b);
        end
        idle(1);
        op = op.next();
      end while (op != op.first());
      mode = mode.next();
    end while (mode != mode.first());

    idle(2);
    // the bound checker counts its own failures
    if (u_dut.u_props.err_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      stop_on_error();
    end
  end

endmodule

//--- files.f
hw/simd_alu_pkg.sv
hw/simd_lane_ctrl.sv
hw/simd_byte_lane.sv
hw/simd_lane_merge.sv
hw/simd_alu.sv
test/simd_alu_properties.sv
test/tb_simd_alu.sv

//--- run.sh
#!/bin/sh
# build and run the SIMD ALU testbench with Verilator, pass only if the log holds the pass line
rm -f sim.log
verilator --binary --assert -Wno-fatal -f files.f --top-module tb_simd_alu -o tb_sim \
  > sim.log 2>&1 \
  && ./obj_dir/tb_sim >> sim.log 2>&1
grep -q 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
